//--- Makefile
TOP = mem_hier_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module mem_hier_top

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -o $(TOP) --Mdir obj_dir
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- include/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// byte address width
`define MEM_ADDR_W 32

// one cache line, 32 bytes
`define MEM_LINE_W 256

// burst port data width
`define MEM_BEAT_W 64
`define MEM_BEATS  4    // beats per line

`define MEM_SETS   8    // direct mapped, one line per set

`endif

//--- src/burst_adaptor.sv
`timescale 1ns/100ps
`include "mem_defs.svh"

module burst_adaptor (
    input  logic                    clk,
    input  logic                    rst,
    input  mem_pkg::line_req_t      line_req_i,
    output mem_pkg::line_rsp_t      line_rsp_o,
    output logic [`MEM_ADDR_W-1:0]  bmem_addr_o,
    output logic                    bmem_read_o,
    output logic                    bmem_write_o,
    output logic [`MEM_BEAT_W-1:0]  bmem_wdata_o,
    input  logic [`MEM_BEAT_W-1:0]  bmem_rdata_i,
    input  logic                    bmem_resp_i
);

    localparam int CNT_W = $clog2(`MEM_BEATS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RD,
        S_WR,
        S_DONE
    } state_t;

    state_t state_q;
    logic [CNT_W-1:0] cnt_q;                            // beats done so far
    logic [`MEM_ADDR_W-1:0] addr_q;
    logic [`MEM_LINE_W-1:0] buf_q;                      // outgoing or incoming line
    logic last_beat;

    assign last_beat = bmem_resp_i && (cnt_q == CNT_W'(`MEM_BEATS - 1));

    assign bmem_addr_o  = addr_q;
    assign bmem_read_o  = (state_q == S_RD);
    assign bmem_write_o = (state_q == S_WR);
    assign bmem_wdata_o = buf_q[`MEM_BEAT_W-1:0];       // lowest beat first

    assign line_rsp_o.resp = (state_q == S_DONE);       // one cycle after 4th beat
    assign line_rsp_o.line = buf_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    cnt_q <= '0;
                    if (line_req_i.read) begin
                        state_q <= S_RD;
                    end else if (line_req_i.write) begin
                        state_q <= S_WR;
                    end
                end
                S_RD, S_WR: begin
                    if (bmem_resp_i) begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                    if (last_beat) begin
                        state_q <= S_DONE;
                    end
                end
                default: state_q <= S_IDLE;             // S_DONE lasts one cycle
            endcase
        end
    end

    // shift right per beat, new read beat enters at the top
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE) begin
            addr_q <= line_req_i.addr;
            buf_q  <= line_req_i.line;
        end else if ((state_q == S_RD || state_q == S_WR) && bmem_resp_i) begin
            buf_q <= {bmem_rdata_i, buf_q[`MEM_LINE_W-1:`MEM_BEAT_W]};
        end
    end

endmodule

//--- src/line_arbiter.sv
`timescale 1ns/100ps

module line_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  mem_pkg::line_req_t   data_req_i,
    output mem_pkg::line_rsp_t   data_rsp_o,
    input  mem_pkg::line_req_t   ifetch_req_i,
    output mem_pkg::line_rsp_t   ifetch_rsp_o,
    output mem_pkg::line_req_t   mem_req_o,
    input  mem_pkg::line_rsp_t   mem_rsp_i
);

    logic busy_q;                                       // a transfer is in flight
    logic gnt_data_q;                                   // owner of that transfer
    logic data_pending;
    logic ifetch_pending;
    logic sel_data;

    assign data_pending   = data_req_i.read | data_req_i.write;
    assign ifetch_pending = ifetch_req_i.read | ifetch_req_i.write;

    // data wins when idle, held grant otherwise
    assign sel_data = busy_q ? gnt_data_q : data_pending;

    assign mem_req_o = sel_data ? data_req_i : ifetch_req_i;   // no added cycle

    // only the owner sees resp, the loser keeps waiting
    assign data_rsp_o.resp   = mem_rsp_i.resp & sel_data;
    assign data_rsp_o.line   = mem_rsp_i.line;
    assign ifetch_rsp_o.resp = mem_rsp_i.resp & ~sel_data;
    assign ifetch_rsp_o.line = mem_rsp_i.line;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q     <= 1'b0;
            gnt_data_q <= 1'b0;
        end else if (!busy_q) begin
            if (data_pending || ifetch_pending) begin
                busy_q     <= 1'b1;
                gnt_data_q <= data_pending;             // lock the choice
            end
        end else if (mem_rsp_i.resp) begin
            busy_q <= 1'b0;                             // re-arbitrate next cycle
        end
    end

endmodule

//--- src/line_cache.sv
`timescale 1ns/100ps
`include "mem_defs.svh"

module line_cache #(
    parameter bit writable = 1'b1               // 0 for the read-only ifetch cache
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid_i,
    input  mem_pkg::mem_req_t    req_i,
    output logic                 req_ready_o,
    output logic                 rsp_valid_o,
    output mem_pkg::mem_rsp_t    rsp_o,
    output mem_pkg::line_req_t   line_req_o,
    input  mem_pkg::line_rsp_t   line_rsp_i
);
    import mem_pkg::*;

    localparam int OFF_W  = $clog2(`MEM_LINE_W / 8);    // byte offset in line
    localparam int WORD_W = OFF_W - 2;                  // word select
    localparam int IDX_W  = $clog2(`MEM_SETS);
    localparam int TAG_W  = `MEM_ADDR_W - IDX_W - OFF_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_WB,
        S_REFILL
    } state_t;

    state_t state_q;

    mem_req_t req_q;                                    // accepted request
    logic [31:0] rdata_q;
    logic rsp_valid_q;

    // line storage
    logic [`MEM_LINE_W-1:0] data_q [`MEM_SETS];
    logic [TAG_W-1:0] tag_q [`MEM_SETS];
    logic [`MEM_SETS-1:0] valid_q;
    logic [`MEM_SETS-1:0] dirty_q;                      // stays zero when not writable

    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] req_idx;
    logic [WORD_W-1:0] req_word;
    logic hit;
    logic do_write;
    logic evict;
    logic [31:0] cur_word;
    logic [31:0] wr_word;

    assign req_tag  = req_q.addr[`MEM_ADDR_W-1 -: TAG_W];
    assign req_idx  = req_q.addr[OFF_W +: IDX_W];
    assign req_word = req_q.addr[2 +: WORD_W];

    assign hit      = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
    assign do_write = writable && req_q.write;          // ifetch writes read back
    assign evict    = writable && valid_q[req_idx] && dirty_q[req_idx];
    assign cur_word = data_q[req_idx][req_word*32 +: 32];

    // byte merge, also the response word on a write
    always_comb begin
        wr_word = cur_word;
        for (int b = 0; b < 4; b++) begin
            if (do_write && req_q.wmask[b]) begin
                wr_word[b*8 +: 8] = req_q.wdata[b*8 +: 8];
            end
        end
    end

    assign req_ready_o = (state_q == S_IDLE);           // one request at a time
    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o.rdata = rdata_q;

    // line port levels come straight from the state register
    always_comb begin
        line_req_o.addr  = {req_tag, req_idx, {OFF_W{1'b0}}};   // refill address
        if (state_q == S_WB) begin
            line_req_o.addr = {tag_q[req_idx], req_idx, {OFF_W{1'b0}}}; // victim
        end
        line_req_o.read  = (state_q == S_REFILL);
        line_req_o.write = writable && (state_q == S_WB);
        line_req_o.line  = data_q[req_idx];             // victim data
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= S_IDLE;
            valid_q     <= '0;
            dirty_q     <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;                        // single cycle pulse
            case (state_q)
                S_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (hit) begin
                        rsp_valid_q <= 1'b1;
                        state_q     <= S_IDLE;
                        if (do_write) begin
                            dirty_q[req_idx] <= 1'b1;
                        end
                    end else if (evict) begin
                        state_q <= S_WB;                // dirty victim goes out first
                    end else begin
                        state_q <= S_REFILL;
                    end
                end
                S_WB: begin
                    if (line_rsp_i.resp) begin
                        state_q <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (line_rsp_i.resp) begin
                        valid_q[req_idx] <= 1'b1;
                        dirty_q[req_idx] <= 1'b0;
                        state_q          <= S_LOOKUP;   // replay as a hit
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= req_i;
        end
        if (state_q == S_LOOKUP && hit) begin
            rdata_q <= wr_word;
            if (do_write) begin
                data_q[req_idx][req_word*32 +: 32] <= wr_word;
            end
        end
        if (state_q == S_REFILL && line_rsp_i.resp) begin
            data_q[req_idx] <= line_rsp_i.line;
            tag_q[req_idx]  <= req_tag;
        end
    end

endmodule

//--- src/mem_hier_top.sv
`timescale 1ns/100ps
`include "mem_defs.svh"

module mem_hier_top (
    input  logic                    clk,
    input  logic                    rst,
    // instruction fetch port
    input  logic                    ifetch_req_valid_i,
    input  mem_pkg::mem_req_t       ifetch_req_i,
    output logic                    ifetch_req_ready_o,
    output logic                    ifetch_rsp_valid_o,
    output mem_pkg::mem_rsp_t       ifetch_rsp_o,
    // load/store port
    input  logic                    data_req_valid_i,
    input  mem_pkg::mem_req_t       data_req_i,
    output logic                    data_req_ready_o,
    output logic                    data_rsp_valid_o,
    output mem_pkg::mem_rsp_t       data_rsp_o,
    // burst memory
    output logic [`MEM_ADDR_W-1:0]  bmem_addr_o,
    output logic                    bmem_read_o,
    output logic                    bmem_write_o,
    output logic [`MEM_BEAT_W-1:0]  bmem_wdata_o,
    input  logic [`MEM_BEAT_W-1:0]  bmem_rdata_i,
    input  logic                    bmem_resp_i
);
    import mem_pkg::*;

    line_req_t icache_line_req;     // icache -> arbiter
    line_rsp_t icache_line_rsp;     // icache <- arbiter
    line_req_t dcache_line_req;     // dcache -> arbiter
    line_rsp_t dcache_line_rsp;     // dcache <- arbiter
    line_req_t mem_line_req;        // arbiter -> adaptor
    line_rsp_t mem_line_rsp;        // arbiter <- adaptor

    line_cache #(.writable(1'b0)) icache (
        .clk, .rst,
        .req_valid_i (ifetch_req_valid_i), .req_i (ifetch_req_i),
        .req_ready_o (ifetch_req_ready_o),
        .rsp_valid_o (ifetch_rsp_valid_o), .rsp_o (ifetch_rsp_o),
        .line_req_o  (icache_line_req),    .line_rsp_i (icache_line_rsp)
    );

    line_cache #(.writable(1'b1)) dcache (
        .clk, .rst,
        .req_valid_i (data_req_valid_i), .req_i (data_req_i),
        .req_ready_o (data_req_ready_o),
        .rsp_valid_o (data_rsp_valid_o), .rsp_o (data_rsp_o),
        .line_req_o  (dcache_line_req),  .line_rsp_i (dcache_line_rsp)
    );

    line_arbiter arbiter (
        .clk, .rst,
        .data_req_i   (dcache_line_req), .data_rsp_o   (dcache_line_rsp),
        .ifetch_req_i (icache_line_req), .ifetch_rsp_o (icache_line_rsp),
        .mem_req_o    (mem_line_req),    .mem_rsp_i    (mem_line_rsp)
    );

    burst_adaptor adaptor (
        .clk, .rst,
        .line_req_i   (mem_line_req),  .line_rsp_o   (mem_line_rsp),
        .bmem_addr_o, .bmem_read_o, .bmem_write_o, .bmem_wdata_o,
        .bmem_rdata_i, .bmem_resp_i
    );

endmodule

//--- src/mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

    // client word request
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;   // word aligned
        logic                   write;
        logic [3:0]             wmask;  // one bit per byte
        logic [31:0]            wdata;
    } mem_req_t;

    // client word response
    typedef struct packed {
        logic [31:0] rdata;             // merged word on a write
    } mem_rsp_t;

    // cache to memory side, held until resp
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;   // line aligned
        logic                   read;
        logic                   write;
        logic [`MEM_LINE_W-1:0] line;   // writeback data
    } line_req_t;

    // memory side back to cache
    typedef struct packed {
        logic                   resp;   // one cycle, ends the transfer
        logic [`MEM_LINE_W-1:0] line;   // refill data
    } line_rsp_t;

endpackage

//--- verification/mem_hier_asserts.sv
`timescale 1ns/100ps

module mem_hier_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 req_valid_i,
    input mem_pkg::mem_req_t    req_i,
    input logic                 req_ready_i,
    input logic                 rsp_valid_i,
    input mem_pkg::line_req_t   line_req_i,
    input mem_pkg::line_rsp_t   line_rsp_i
);

    // client holds a stalled request
    req_held: assert property (@(posedge clk) disable iff (rst)
        (req_valid_i && !req_ready_i) |=> (req_valid_i && $stable(req_i)))
        else $error("word request changed while stalled");

    rsp_pulse: assert property (@(posedge clk) disable iff (rst)
        rsp_valid_i |=> !rsp_valid_i)
        else $error("rsp_valid longer than one cycle");

    rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(line_req_i.read && line_req_i.write))
        else $error("line read and write both high");

    // line request frozen until resp ends it
    line_held: assert property (@(posedge clk) disable iff (rst)
        ((line_req_i.read || line_req_i.write) && !line_rsp_i.resp) |=> $stable(line_req_i))
        else $error("line request dropped or changed before resp");

endmodule

bind line_cache mem_hier_asserts asserts_i (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_i (req_ready_o),
    .rsp_valid_i (rsp_valid_o),
    .line_req_i  (line_req_o),
    .line_rsp_i  (line_rsp_i)
);

//--- verification/mem_hier_tb.sv
`timescale 1ns/100ps
`include "mem_defs.svh"

module mem_hier_tb;
    import mem_pkg::*;

    localparam int CLK_NS      = 4;
    localparam int N_REQS      = 24;                    // requests issued over all tests
    localparam int MISS_CYC    = 30;                    // worst case miss incl. writeback
    localparam int WATCHDOG_NS = (N_REQS * MISS_CYC + 10) * CLK_NS;

    logic clk;
    logic rst;
    logic ifetch_req_valid;
    mem_req_t ifetch_req;
    logic ifetch_req_ready;
    logic ifetch_rsp_valid;
    mem_rsp_t ifetch_rsp;
    logic data_req_valid;
    mem_req_t data_req;
    logic data_req_ready;
    logic data_rsp_valid;
    mem_rsp_t data_rsp;
    logic [`MEM_ADDR_W-1:0] bmem_addr;
    logic bmem_read;
    logic bmem_write;
    logic [`MEM_BEAT_W-1:0] bmem_wdata;
    logic [`MEM_BEAT_W-1:0] bmem_rdata;
    logic bmem_resp;

    logic [63:0] mem [bit [31:0]];                      // current beats, by beat index
    logic [63:0] orig [bit [31:0]];                     // first fill, backs the image
    logic [31:0] img [bit [31:0]];                      // written words, by byte address

    int unsigned beat_k = 0;                            // beat within current burst
    int unsigned wait_cnt = 0;
    int unsigned bmem_cycles = 0;                       // cycles with a burst in flight
    int unsigned wr_beats = 0;
    logic [31:0] beat_addr;
    int err_cnt = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    mem_hier_top mem_hier_top_i (
        .clk                (clk),
        .rst                (rst),
        .ifetch_req_valid_i (ifetch_req_valid),
        .ifetch_req_i       (ifetch_req),
        .ifetch_req_ready_o (ifetch_req_ready),
        .ifetch_rsp_valid_o (ifetch_rsp_valid),
        .ifetch_rsp_o       (ifetch_rsp),
        .data_req_valid_i   (data_req_valid),
        .data_req_i         (data_req),
        .data_req_ready_o   (data_req_ready),
        .data_rsp_valid_o   (data_rsp_valid),
        .data_rsp_o         (data_rsp),
        .bmem_addr_o        (bmem_addr),
        .bmem_read_o        (bmem_read),
        .bmem_write_o       (bmem_write),
        .bmem_wdata_o       (bmem_wdata),
        .bmem_rdata_i       (bmem_rdata),
        .bmem_resp_i        (bmem_resp)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // lazy random fill, first touch decides the original contents
    function automatic logic [63:0] fill_beat(input logic [31:0] bidx);
        if (!orig.exists(bidx)) begin
            orig[bidx] = {$urandom, $urandom};
            mem[bidx]  = orig[bidx];
        end
        return mem[bidx];
    endfunction

    // expected word, from writes so far or the original fill
    function automatic logic [31:0] image_word(input logic [31:0] addr);
        logic [63:0] beat;
        if (img.exists(addr)) begin
            return img[addr];
        end
        if (!orig.exists(addr >> 3)) begin
            void'(fill_beat(addr >> 3));
        end
        beat = orig[addr >> 3];
        return addr[2] ? beat[63:32] : beat[31:0];      // little endian within the beat
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [3:0] mask,
                                                input logic [31:0] new_w);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // burst memory, one beat every third cycle while read or write is held
    always @(negedge clk) begin
        bmem_resp = 1'b0;
        if (rst) begin
            beat_k   = 0;
            wait_cnt = 0;
        end else if (bmem_read || bmem_write) begin
            bmem_cycles++;
            if (wait_cnt < 2) begin
                wait_cnt++;                             // 2 cycle beat delay
            end else begin
                beat_addr = (bmem_addr >> 3) + beat_k;
                if (bmem_write) begin
                    void'(fill_beat(beat_addr));
                    mem[beat_addr] = bmem_wdata;
                    wr_beats++;
                end else begin
                    bmem_rdata = fill_beat(beat_addr);
                end
                bmem_resp = 1'b1;
                wait_cnt  = 0;
                beat_k    = (beat_k + 1) % `MEM_BEATS;
            end
        end
    end

    task automatic check_rsp(input string name, input mem_rsp_t exp, input mem_rsp_t act);
        if (act !== exp) begin
            $display("ERR %s: expected %08h, actual %08h", name, exp.rdata, act.rdata);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: expected %b, actual %b", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("%s: ok", name);
            pass_cnt++;
        end else begin
            $display("%s: %0d check(s) failed", name, err_cnt - errs_before);
            fail_cnt++;
        end
    endtask

    // one valid/ready transfer, then wait for the response pulse
    task automatic issue_request(input bit on_data, input logic [31:0] addr, input logic write,
                                 input logic [3:0] mask, input logic [31:0] wdata,
                                 output mem_rsp_t rsp);
        mem_req_t req;
        req.addr  = addr;
        req.write = write;
        req.wmask = mask;
        req.wdata = wdata;
        @(negedge clk);
        if (on_data) begin
            data_req       = req;
            data_req_valid = 1'b1;
        end else begin
            ifetch_req       = req;
            ifetch_req_valid = 1'b1;
        end
        while (!(on_data ? data_req_ready : ifetch_req_ready)) @(negedge clk);
        @(negedge clk);                                 // taken at the edge just passed
        if (on_data) begin
            data_req_valid = 1'b0;
        end else begin
            ifetch_req_valid = 1'b0;
        end
        while (!(on_data ? data_rsp_valid : ifetch_rsp_valid)) @(negedge clk);
        rsp = on_data ? data_rsp : ifetch_rsp;
    endtask

    task automatic data_read(input string name, input logic [31:0] addr);
        mem_rsp_t exp;
        mem_rsp_t act;
        exp.rdata = image_word(addr);
        issue_request(1'b1, addr, 1'b0, 4'h0, 32'h0, act);
        check_rsp(name, exp, act);
    endtask

    task automatic data_write(input string name, input logic [31:0] addr,
                              input logic [3:0] mask, input logic [31:0] wdata);
        mem_rsp_t exp;
        mem_rsp_t act;
        exp.rdata = merge_bytes(image_word(addr), mask, wdata);
        issue_request(1'b1, addr, 1'b1, mask, wdata, act);
        img[addr] = exp.rdata;                          // write done, image follows
        check_rsp(name, exp, act);
    endtask

    // write flag set is a read on the ifetch side
    task automatic ifetch_read(input string name, input logic [31:0] addr, input logic write);
        mem_rsp_t exp;
        mem_rsp_t act;
        exp.rdata = image_word(addr);
        issue_request(1'b0, addr, write, 4'hf, ~exp.rdata, act);
        check_rsp(name, exp, act);
    endtask

    task automatic reset_state();
        int e0;
        e0 = err_cnt;
        rst = 1'b1;
        repeat (10) begin
            @(negedge clk);
            check_bit("reset data rsp_valid", 1'b0, data_rsp_valid);
            check_bit("reset ifetch rsp_valid", 1'b0, ifetch_rsp_valid);
            check_bit("reset bmem_read", 1'b0, bmem_read);
            check_bit("reset bmem_write", 1'b0, bmem_write);
        end
        rst = 1'b0;
        @(negedge clk);
        check_bit("reset data rsp_valid", 1'b0, data_rsp_valid);
        check_bit("reset ifetch rsp_valid", 1'b0, ifetch_rsp_valid);
        check_bit("reset data ready", 1'b1, data_req_ready);
        check_bit("reset ifetch ready", 1'b1, ifetch_req_ready);
        check_bit("reset bmem idle", 1'b0, bmem_read | bmem_write);
        report_test("reset", e0);
    endtask

    task automatic read_miss_then_hit();
        int e0;
        int unsigned cyc0;
        e0 = err_cnt;
        data_read("read_miss_hit", 32'h0000_1040);      // miss, refill
        cyc0 = bmem_cycles;
        data_read("read_miss_hit", 32'h0000_1048);      // same line
        check_bit("read_miss_hit no bmem", 1'b1, bmem_cycles == cyc0);
        report_test("read_miss_hit", e0);
    endtask

    task automatic masked_writes();
        int e0;
        e0 = err_cnt;
        data_write("masked_writes", 32'h0000_2060, 4'b0001, $urandom);   // write allocate
        data_write("masked_writes", 32'h0000_2064, 4'b0110, $urandom);
        data_write("masked_writes", 32'h0000_2068, 4'b1000, $urandom);
        data_write("masked_writes", 32'h0000_206c, 4'b1111, $urandom);
        data_write("masked_writes", 32'h0000_2070, 4'b0000, $urandom);   // nothing changes
        data_write("masked_writes", 32'h0000_2074, 4'b1010, $urandom);
        data_write("masked_writes", 32'h0000_2060, 4'b1100, $urandom);   // second merge
        for (int w = 0; w < 6; w++) begin
            data_read("masked_writes", 32'h0000_2060 + 4 * w);
        end
        report_test("masked_writes", e0);
    endtask

    task automatic dirty_eviction();
        int e0;
        int unsigned wr0;
        logic [31:0] base;
        logic [31:0] alias_addr;
        e0 = err_cnt;
        base = 32'h0000_3080;
        alias_addr = base + `MEM_SETS * 32;             // same index, other tag
        data_write("dirty_eviction", base, 4'hf, $urandom);
        wr0 = wr_beats;
        data_read("dirty_eviction", alias_addr);
        check_bit("dirty_eviction writeback", 1'b1, (wr_beats - wr0) == `MEM_BEATS);
        data_read("dirty_eviction", base);              // refill brings the write back
        report_test("dirty_eviction", e0);
    endtask

    task automatic concurrent_misses();
        int e0;
        e0 = err_cnt;
        fork
            ifetch_read("concurrent_miss", 32'h0000_40a0, 1'b0);
            data_read("concurrent_miss", 32'h0000_50c0);
        join
        ifetch_read("ifetch_write_ignored", 32'h0000_40a4, 1'b1);
        data_read("ifetch_write_ignored", 32'h0000_40a4);   // memory untouched too
        report_test("concurrent_miss", e0);
    endtask

    // second request waits on a busy cache with valid held high
    task automatic back_pressure();
        int e0;
        mem_rsp_t exp_a;
        mem_rsp_t exp_b;
        mem_rsp_t act;
        e0 = err_cnt;
        exp_a.rdata = image_word(32'h0000_60e0);
        exp_b.rdata = image_word(32'h0000_60e4);
        @(negedge clk);
        data_req.addr  = 32'h0000_60e0;                 // miss, set 7 still empty
        data_req.write = 1'b0;
        data_req.wmask = 4'h0;
        data_req.wdata = 32'h0;
        data_req_valid = 1'b1;
        while (!data_req_ready) @(negedge clk);
        @(negedge clk);                                 // taken, cache now busy
        check_bit("back_pressure ready", 1'b0, data_req_ready);
        data_req.addr = 32'h0000_60e4;                  // next request, held while stalled
        while (!data_rsp_valid) @(negedge clk);
        act = data_rsp;
        check_rsp("back_pressure first", exp_a, act);
        @(negedge clk);                                 // second one taken once idle
        data_req_valid = 1'b0;
        while (!data_rsp_valid) @(negedge clk);
        act = data_rsp;
        check_rsp("back_pressure second", exp_b, act);
        report_test("back_pressure", e0);
    endtask

    initial begin
        void'($urandom(32'h217ae0be));
        clk              = 1'b0;
        rst              = 1'b1;
        ifetch_req_valid = 1'b0;
        ifetch_req       = '0;
        data_req_valid   = 1'b0;
        data_req         = '0;
        bmem_rdata       = '0;
        bmem_resp        = 1'b0;
        reset_state();
        read_miss_then_hit();
        masked_writes();
        dirty_eviction();
        concurrent_misses();
        back_pressure();
        $display("tests: %0d passed, %0d failed, %0d check errors", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog, sized by request count
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
src/mem_pkg.sv
src/line_cache.sv
src/line_arbiter.sv
src/burst_adaptor.sv
src/mem_hier_top.sv
verification/mem_hier_asserts.sv
verification/mem_hier_tb.sv
